// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS := --binary --timing
LINT_FLAGS := --lint-only -Wall --timing
TOP := core_tb
FILELIST := rvcore.f
OBJ_DIR := obj_dir
LOG := sim.log
PASS_MSG := PASS: all tests

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -qx "$(PASS_MSG)" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== bench/core_patterns.hex ====
// Program words from @000 in fetch order. The last word is the self-jump loop.
// Store records from @100, one per line as address then data. Address ffffffff ends the list.
@000
00500093 ffd00113 002081b3 10302023  // ADDI x1 = 5, ADDI x2 = -3, ADD uses x2 at once, SW.
40208233 10402223 0020f2b3 10502423  // SUB, SW, AND, SW.
0020e333 10602623 0020c3b3 10702823  // OR, SW, XOR, SW.
00112433 10802a23                    // SLT x8 = (x2 < x1), SW.
123454b7 67848493 10902c23           // LUI, ADDI on its result, SW to 0x118.
11802503 00150593 10b02e23           // LW from 0x118, use of the load at once, SW.
00108663 1e102823 1e202a23           // BEQ taken over two stores that must vanish.
00109463 12102023                    // BNE not taken, SW.
00c0066f 1e102c23 1e202e23 12c02223  // JAL x12 over two stores, SW of the link.
0000006f                             // Self-jump.
@100
00000100 00000002
00000104 00000008
00000108 00000005
0000010c fffffffd
00000110 fffffff8
00000114 00000001
00000118 12345678
0000011c 12345679
00000120 00000005
00000124 00000068
ffffffff ffffffff

// ==== bench/core_tb.sv ====
/*
 * core_tb
 * Runs the pattern program on the core twice, first without and then
 * with random memory waits, and checks every store against the list.
 */
module core_tb import rv_pkg::*; ();

	localparam int CLK_PERIOD = 40;
	localparam int RESET_CYCLES = 4;
	localparam int NUM_RUNS = 2;
	localparam int DRIVE_DLY = 5;
	localparam int SAMPLE_DLY = 3;
	localparam int REC_BASE = 256;	// First word of the store records.
	localparam logic [XLEN-1:0] SELF_JUMP = 32'h0000006f;
	localparam logic [XLEN-1:0] REC_END = 32'hffffffff;

	logic clk;
	logic rst_i;
	logic [XLEN-1:0] instr_i;
	logic [XLEN-1:0] pc_o;
	logic [XLEN-1:0] mem_addr_o;
	logic [XLEN-1:0] mem_wdata_o;
	logic mem_we_o;
	logic mem_re_o;
	logic [XLEN-1:0] mem_rdata_i;
	logic mem_wait_i;

	logic [XLEN-1:0] patterns [0:511];
	logic [XLEN-1:0] imem [0:255];
	logic [XLEN-1:0] dmem [0:255];
	int seed = 45028;
	int prog_len = 0;
	int n_records = 0;
	int rec_idx = 0;
	int store_count = 0;
	int loop_hits = 0;
	logic [XLEN-1:0] loop_pc;
	bit random_waits = 1'b0;
	string run_tag = "reset";

	core dut0 (
		.clk         (clk),
		.rst_i       (rst_i),
		.instr_i     (instr_i),
		.pc_o        (pc_o),
		.mem_addr_o  (mem_addr_o),
		.mem_wdata_o (mem_wdata_o),
		.mem_we_o    (mem_we_o),
		.mem_re_o    (mem_re_o),
		.mem_rdata_i (mem_rdata_i),
		.mem_wait_i  (mem_wait_i)
	);

	// Both memories answer in the same cycle.
	assign instr_i = imem[pc_o[9:2]];
	assign mem_rdata_i = dmem[mem_addr_o[9:2]];

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	initial begin
		logic [31:0] r;
		mem_wait_i = 1'b0;
		forever begin
			@(posedge clk);
			#(DRIVE_DLY);
			r = $random(seed);
			mem_wait_i = random_waits && r[0]; // About half the cycles wait.
		end
	end

	task automatic abort_run(input string reason);
		$display("%s", reason);
		$display("FAIL: see errors above");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input logic [XLEN-1:0] expected,
			input logic [XLEN-1:0] actual);
		if (expected !== actual) begin
			abort_run($sformatf("ERROR %s: expected %h, actual %h", name, expected, actual));
		end
	endtask

	task automatic load_patterns();
		for (int i = 0; i < 512; i++) begin
			patterns[i] = '0;
		end
		$readmemh("bench/core_patterns.hex", patterns);
		for (int i = 0; i < 256; i++) begin
			imem[i] = patterns[i];
			if (prog_len == 0 && patterns[i] == SELF_JUMP) begin
				prog_len = i + 1;
			end
		end
		while (REC_BASE + 2 * n_records + 1 < 512 &&
				patterns[REC_BASE + 2 * n_records] !== REC_END) begin
			n_records++;
		end
		if (prog_len == 0 || n_records == 0) begin
			abort_run("The pattern file lacks a final self-jump or any store record.");
		end
		loop_pc = XLEN'((prog_len - 1) * 4);
	endtask

	// Every word differs, so a load from a wrong address shows up.
	task automatic fill_data_memory();
		for (int i = 0; i < 256; i++) begin
			dmem[i] = {8'hd5, 8'(i), 8'(~i), 8'(i) ^ 8'h5a};
		end
	endtask

	task automatic apply_reset();
		rst_i = 1'b1;
		repeat (RESET_CYCLES) begin
			@(posedge clk);
			#(SAMPLE_DLY);
			check_value({run_tag, " reset pc_o"}, '0, pc_o);
			check_value({run_tag, " reset mem_we_o"}, '0, XLEN'(mem_we_o));
			check_value({run_tag, " reset mem_re_o"}, '0, XLEN'(mem_re_o));
		end
		#(DRIVE_DLY - SAMPLE_DLY);
		rst_i = 1'b0;
	endtask

	task automatic run_program(input string tag, input bit with_waits);
		run_tag = tag;
		random_waits = with_waits;
		apply_reset();
		fill_data_memory();
		rec_idx = 0;
		store_count = 0;
		loop_hits = 0;
		// The self-jump has run once when its address shows up a second time.
		while (loop_hits < 2) begin
			@(posedge clk);
			#(DRIVE_DLY);
		end
		check_value({tag, " store count"}, XLEN'(n_records), XLEN'(store_count));
	endtask

	// A store completes in the first cycle its wait is low.
	always @(negedge clk) begin
		if (!rst_i && mem_we_o && !mem_wait_i) begin
			store_count++;
			if (rec_idx >= n_records) begin
				abort_run($sformatf("In the %s the core stored %h to %h after the last record.",
					run_tag, mem_wdata_o, mem_addr_o));
			end else begin
				check_value($sformatf("%s store %0d address", run_tag, rec_idx),
					patterns[REC_BASE + 2 * rec_idx], mem_addr_o);
				check_value($sformatf("%s store %0d data", run_tag, rec_idx),
					patterns[REC_BASE + 2 * rec_idx + 1], mem_wdata_o);
				dmem[mem_addr_o[9:2]] = mem_wdata_o;
				rec_idx++;
			end
		end
		if (!rst_i && pc_o == loop_pc) begin
			loop_hits++;
		end
	end

	initial begin
		int limit;
		wait (prog_len > 0);
		limit = NUM_RUNS * (20 * prog_len + RESET_CYCLES + 1) * CLK_PERIOD;
		#(limit);
		$display("Timeout: the program did not finish both runs within %0d time units.", limit);
		$display("FAIL: see errors above");
		$fatal(1);
	end

	initial begin
		rst_i = 1'b1;
		load_patterns();
		run_program("run without waits", 1'b0);
		run_program("run with random waits", 1'b1);
		$display("PASS: all tests");
		$finish;
	end

endmodule

// ==== rvcore.f ====
src/rv_pkg.sv
src/ex_bus_if.sv
src/pipe_reg.sv
src/fetch_unit.sv
src/decode_stage.sv
src/reg_file.sv
src/exec_stage.sv
src/core.sv
bench/core_tb.sv

// ==== src/core.sv ====
/*
 * core
 * Three-stage RV32I subset pipeline: fetch, decode, execute.
 * Builds the memory-wait hold and the jump flush for all stages.
 */
module core import rv_pkg::*; #(
	parameter logic [XLEN-1:0] RESET_PC = '0
) (
	input  logic            clk,
	input  logic            rst_i,
	input  logic [XLEN-1:0] instr_i,
	output logic [XLEN-1:0] pc_o,
	output logic [XLEN-1:0] mem_addr_o,
	output logic [XLEN-1:0] mem_wdata_o,
	output logic            mem_we_o,
	output logic            mem_re_o,
	input  logic [XLEN-1:0] mem_rdata_i,
	input  logic            mem_wait_i
);

	logic hold;
	logic jump_taken;
	logic [XLEN-1:0] jump_target;
	if_id_t fetch_word;
	if_id_t id_word;
	logic id_valid;
	id_ex_t ex_op;
	logic ex_valid;
	logic [REG_AW-1:0] rs1_addr;
	logic [REG_AW-1:0] rs2_addr;
	logic [XLEN-1:0] rs1_data;
	logic [XLEN-1:0] rs2_data;
	logic rd_we;
	logic [REG_AW-1:0] rd_addr;
	logic [XLEN-1:0] rd_data;

	ex_bus_if ex_bus ();

	// Only a memory instruction in execute can stall the pipeline.
	assign hold = mem_wait_i && ex_valid && (ex_op.is_load || ex_op.is_store);
	assign ex_bus.flush = jump_taken;

	fetch_unit #(.RESET_PC(RESET_PC)) u_fetch (
		.clk      (clk),
		.rst_i    (rst_i),
		.hold_i   (hold),
		.jump_i   (jump_taken),
		.target_i (jump_target),
		.pc_o     (pc_o)
	);

	assign fetch_word.instr = instr_i;
	assign fetch_word.pc = pc_o;

	pipe_reg #(.payload_t(if_id_t)) if_id_reg (
		.clk     (clk),
		.rst_i   (rst_i),
		.hold_i  (hold),
		.flush_i (jump_taken),
		.valid_i (1'b1),	// Fetch has a word every cycle.
		.data_i  (fetch_word),
		.valid_o (id_valid),
		.data_o  (id_word)
	);

	decode_stage u_decode (
		.valid_i    (id_valid),
		.fetch_i    (id_word),
		.rs1_addr_o (rs1_addr),
		.rs2_addr_o (rs2_addr),
		.rs1_data_i (rs1_data),
		.rs2_data_i (rs2_data),
		.ex_o       (ex_bus)
	);

	reg_file u_regs (
		.clk      (clk),
		.rst_i    (rst_i),
		.we_i     (rd_we),
		.waddr_i  (rd_addr),
		.wdata_i  (rd_data),
		.raddr1_i (rs1_addr),
		.raddr2_i (rs2_addr),
		.rdata1_o (rs1_data),
		.rdata2_o (rs2_data)
	);

	pipe_reg #(.payload_t(id_ex_t)) id_ex_reg (
		.clk     (clk),
		.rst_i   (rst_i),
		.hold_i  (hold),
		.flush_i (ex_bus.flush),
		.valid_i (ex_bus.valid),
		.data_i  (ex_bus.bundle),
		.valid_o (ex_valid),
		.data_o  (ex_op)
	);

	exec_stage u_exec (
		.valid_i     (ex_valid),
		.op_i        (ex_op),
		.hold_i      (hold),
		.mem_addr_o  (mem_addr_o),
		.mem_wdata_o (mem_wdata_o),
		.mem_we_o    (mem_we_o),
		.mem_re_o    (mem_re_o),
		.mem_rdata_i (mem_rdata_i),
		.rd_we_o     (rd_we),
		.rd_addr_o   (rd_addr),
		.rd_data_o   (rd_data),
		.jump_o      (jump_taken),
		.target_o    (jump_target)
	);

endmodule

// ==== src/decode_stage.sv ====
/*
 * decode_stage
 * Splits the fetched word into register addresses and immediates,
 * selects the ALU operands and the control flags for execute.
 * Anything not in the supported subset leaves as a bubble.
 */
module decode_stage import rv_pkg::*; (
	input  logic              valid_i,
	input  if_id_t            fetch_i,
	output logic [REG_AW-1:0] rs1_addr_o,
	output logic [REG_AW-1:0] rs2_addr_o,
	input  logic [XLEN-1:0]   rs1_data_i,
	input  logic [XLEN-1:0]   rs2_data_i,
	ex_bus_if.producer        ex_o
);

	logic [XLEN-1:0] instr;
	logic [6:0] opcode;
	logic [2:0] funct3;
	logic alt_op;
	logic [XLEN-1:0] imm_i;
	logic [XLEN-1:0] imm_s;
	logic [XLEN-1:0] imm_b;
	logic [XLEN-1:0] imm_u;
	logic [XLEN-1:0] imm_j;
	id_ex_t op;

	assign instr = fetch_i.instr;
	assign opcode = instr[6:0];
	assign funct3 = instr[14:12];
	assign alt_op = instr[30]; // Selects SUB over ADD.

	assign rs1_addr_o = instr[19:15];
	assign rs2_addr_o = instr[24:20];

	assign imm_i = {{20{instr[31]}}, instr[31:20]};
	assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
	assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
	assign imm_u = {instr[31:12], 12'b0};
	assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

	always_comb begin
		op = '0;
		op.alu_op = ALU_ADD;
		op.op_a = rs1_data_i;
		op.op_b = rs2_data_i;
		op.store_data = rs2_data_i;
		op.target = fetch_i.pc + ((opcode == OPC_JAL) ? imm_j : imm_b);
		op.link = fetch_i.pc + XLEN'(4);
		op.rd = instr[11:7];
		case (opcode)
			OPC_OP: begin
				op.reg_we = 1'b1;
				case (funct3)
					3'b000: op.alu_op = alt_op ? ALU_SUB : ALU_ADD;
					3'b010: op.alu_op = ALU_SLT;
					3'b100: op.alu_op = ALU_XOR;
					3'b110: op.alu_op = ALU_OR;
					3'b111: op.alu_op = ALU_AND;
					default: op.reg_we = 1'b0;
				endcase
			end
			OPC_OP_IMM: begin
				op.op_b = imm_i;
				op.reg_we = (funct3 == 3'b000); // ADDI only.
			end
			OPC_LUI: begin
				op.alu_op = ALU_PASS_B;
				op.op_b = imm_u;
				op.reg_we = 1'b1;
			end
			OPC_LOAD: begin
				op.op_b = imm_i;
				op.is_load = (funct3 == 3'b010);
				op.reg_we = (funct3 == 3'b010);
			end
			OPC_STORE: begin
				op.op_b = imm_s;
				op.is_store = (funct3 == 3'b010);
			end
			OPC_BRANCH: begin
				op.is_branch = (funct3[2:1] == 2'b00); // BEQ and BNE.
				op.branch_ne = funct3[0];
			end
			OPC_JAL: begin
				op.is_jump = 1'b1;
				op.reg_we = 1'b1;
			end
			default: ;
		endcase
	end

	assign ex_o.valid = valid_i;
	assign ex_o.bundle = op;

endmodule

// ==== src/ex_bus_if.sv ====
/*
 * ex_bus_if
 * Decoded instruction bundle from decode towards the ID/EX buffer,
 * together with the jump flush that squashes it.
 */
interface ex_bus_if import rv_pkg::*; ();

	logic valid;
	id_ex_t bundle;
	logic flush;	// Driven by the top level from execute's jump.

	modport producer (
		output valid,
		output bundle
	);

	modport buffer (
		input valid,
		input bundle,
		input flush
	);

endinterface

// ==== src/exec_stage.sv ====
/*
 * exec_stage
 * ALU, data memory request, branch resolution and register writeback,
 * all in one combinational step. Writes and redirects wait out a hold.
 */
module exec_stage import rv_pkg::*; (
	input  logic              valid_i,
	input  id_ex_t            op_i,
	input  logic              hold_i,
	output logic [XLEN-1:0]   mem_addr_o,
	output logic [XLEN-1:0]   mem_wdata_o,
	output logic              mem_we_o,
	output logic              mem_re_o,
	input  logic [XLEN-1:0]   mem_rdata_i,
	output logic              rd_we_o,
	output logic [REG_AW-1:0] rd_addr_o,
	output logic [XLEN-1:0]   rd_data_o,
	output logic              jump_o,
	output logic [XLEN-1:0]   target_o
);

	logic [XLEN-1:0] alu_result;
	logic operands_equal;
	logic taken;
	logic commit;

	always_comb begin
		case (op_i.alu_op)
			ALU_ADD: alu_result = op_i.op_a + op_i.op_b;
			ALU_SUB: alu_result = op_i.op_a - op_i.op_b;
			ALU_AND: alu_result = op_i.op_a & op_i.op_b;
			ALU_OR: alu_result = op_i.op_a | op_i.op_b;
			ALU_XOR: alu_result = op_i.op_a ^ op_i.op_b;
			ALU_SLT: alu_result = XLEN'($signed(op_i.op_a) < $signed(op_i.op_b));
			ALU_PASS_B: alu_result = op_i.op_b;
			default: alu_result = '0;
		endcase
	end

	// Loads and stores address memory with base plus offset from the ALU.
	assign mem_addr_o = alu_result;
	assign mem_wdata_o = op_i.store_data;
	assign mem_we_o = valid_i && op_i.is_store;
	assign mem_re_o = valid_i && op_i.is_load;

	assign operands_equal = (op_i.op_a == op_i.op_b);
	assign taken = op_i.is_jump || (op_i.is_branch && (operands_equal ^ op_i.branch_ne));

	// Nothing leaves execute while its memory access is still pending.
	assign commit = valid_i && !hold_i;

	assign jump_o = commit && taken;
	assign target_o = op_i.target;

	assign rd_we_o = commit && op_i.reg_we;
	assign rd_addr_o = op_i.rd;

	always_comb begin
		if (op_i.is_load) begin
			rd_data_o = mem_rdata_i;
		end else if (op_i.is_jump) begin
			rd_data_o = op_i.link; // Return address for JAL.
		end else begin
			rd_data_o = alu_result;
		end
	end

endmodule

// ==== src/fetch_unit.sv ====
/*
 * fetch_unit
 * Program counter. Steps by four each unheld cycle and takes the
 * target from execute when a branch or jump is taken.
 */
module fetch_unit import rv_pkg::*; #(
	parameter logic [XLEN-1:0] RESET_PC = '0
) (
	input  logic            clk,
	input  logic            rst_i,
	input  logic            hold_i,
	input  logic            jump_i,
	input  logic [XLEN-1:0] target_i,
	output logic [XLEN-1:0] pc_o
);

	// A jump is never raised while held, so its priority is safe.
	always_ff @(posedge clk) begin
		if (rst_i) begin
			pc_o <= RESET_PC;
		end else if (jump_i) begin
			pc_o <= target_i;
		end else if (!hold_i) begin
			pc_o <= pc_o + XLEN'(4);
		end
	end

endmodule

// ==== src/pipe_reg.sv ====
/*
 * pipe_reg
 * One registered pipeline stage for any payload type. Valid is cleared
 * by reset or flush, and the whole stage freezes while hold is high.
 */
module pipe_reg #(
	parameter type payload_t = logic [31:0]
) (
	input  logic     clk,
	input  logic     rst_i,
	input  logic     hold_i,
	input  logic     flush_i,
	input  logic     valid_i,
	input  payload_t data_i,
	output logic     valid_o,
	output payload_t data_o
);

	always_ff @(posedge clk) begin
		if (rst_i || flush_i) begin
			valid_o <= 1'b0;
		end else if (!hold_i) begin
			valid_o <= valid_i;
		end
	end

	always_ff @(posedge clk) begin
		if (!hold_i) begin
			data_o <= data_i; // Payload is only meaningful with valid_o.
		end
	end

endmodule

// ==== src/reg_file.sv ====
/*
 * reg_file
 * Thirty-two general registers with x0 tied to zero. A read of the
 * register being written this cycle returns the new value.
 */
module reg_file import rv_pkg::*; (
	input  logic              clk,
	input  logic              rst_i,
	input  logic              we_i,
	input  logic [REG_AW-1:0] waddr_i,
	input  logic [XLEN-1:0]   wdata_i,
	input  logic [REG_AW-1:0] raddr1_i,
	input  logic [REG_AW-1:0] raddr2_i,
	output logic [XLEN-1:0]   rdata1_o,
	output logic [XLEN-1:0]   rdata2_o
);

	logic [XLEN-1:0] regs [0:31];

	always_ff @(posedge clk) begin
		if (rst_i) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (we_i && waddr_i != '0) begin
			regs[waddr_i] <= wdata_i;
		end
	end

	// Write-through keeps decode in step with execute's writeback.
	assign rdata1_o = (raddr1_i == '0) ? '0 :
		(we_i && waddr_i == raddr1_i) ? wdata_i : regs[raddr1_i];
	assign rdata2_o = (raddr2_i == '0) ? '0 :
		(we_i && waddr_i == raddr2_i) ? wdata_i : regs[raddr2_i];

endmodule

// ==== src/rv_pkg.sv ====
/*
 * rv_pkg
 * Shared widths, RV32I opcodes, the ALU operation set and the payload
 * structs that travel through the two pipeline buffers of the core.
 */
package rv_pkg;

	localparam int XLEN = 32;
	localparam int REG_AW = 5;

	// Major opcodes of the supported RV32I subset.
	localparam logic [6:0] OPC_OP = 7'b0110011;
	localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
	localparam logic [6:0] OPC_LUI = 7'b0110111;
	localparam logic [6:0] OPC_LOAD = 7'b0000011;
	localparam logic [6:0] OPC_STORE = 7'b0100011;
	localparam logic [6:0] OPC_BRANCH = 7'b1100011;
	localparam logic [6:0] OPC_JAL = 7'b1101111;

	typedef enum logic [2:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_SLT,
		ALU_PASS_B // LUI passes the upper immediate straight through.
	} alu_op_e;

	// Fetched word and the address it came from.
	typedef struct packed {
		logic [XLEN-1:0] instr;
		logic [XLEN-1:0] pc;
	} if_id_t;

	// Everything execute needs, resolved in decode.
	typedef struct packed {
		alu_op_e alu_op;
		logic [XLEN-1:0] op_a;
		logic [XLEN-1:0] op_b;
		logic [XLEN-1:0] store_data;
		logic [XLEN-1:0] target;	// Branch or jump destination.
		logic [XLEN-1:0] link;		// PC+4 for JAL.
		logic [REG_AW-1:0] rd;
		logic reg_we;
		logic is_load;
		logic is_store;
		logic is_branch;
		logic branch_ne;
		logic is_jump;
	} id_ex_t;

endpackage
